//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 16;

    // Instruction field positions
    localparam int cond_hi = 31;
    localparam int cond_lo = 28;
    localparam int cls_hi  = 27;
    localparam int cls_lo  = 26;
    localparam int i_bit   = 25;
    localparam int opc_hi  = 24;
    localparam int opc_lo  = 21;
    localparam int s_bit   = 20;    // L bit for transfers
    localparam int rn_hi   = 19;
    localparam int rn_lo   = 16;
    localparam int rd_hi   = 15;
    localparam int rd_lo   = 12;
    localparam int imm_hi  = 11;
    localparam int imm_lo  = 0;
    localparam int rm_hi   = 3;
    localparam int rm_lo   = 0;
    localparam int off_hi  = 23;
    localparam int off_lo  = 0;

    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
    typedef logic [xlen-1:0]              word_t;

    localparam word_t    reset_pc = 32'h0000_0000;
    localparam reg_idx_t pc_idx   = 4'd15;    // Never written by the register file

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
    } cond_t;

    typedef enum logic [3:0] {
        OP_AND = 4'd0,
        OP_EOR = 4'd1,
        OP_SUB = 4'd2,
        OP_ADD = 4'd4,
        OP_CMP = 4'd10,
        OP_ORR = 4'd12,
        OP_MOV = 4'd13
    } alu_op_t;

    typedef enum logic [1:0] {
        CLS_DP     = 2'd0,
        CLS_XFER   = 2'd1,
        CLS_BRANCH = 2'd2,
        CLS_UNDEF  = 2'd3
    } instr_class_t;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK
    } cpu_state_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        instr_class_t cls;
        cond_t        cond;
        alu_op_t      op;
        logic         set_flags;
        logic         imm_en;
        logic         load;
        reg_idx_t     rd;
        reg_idx_t     rn;
        reg_idx_t     rm;
        logic [11:0]  imm;
        logic [23:0]  offset;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

endpackage

`default_nettype wire

//--- verilog/cycle_control.sv
`timescale 1ns/10ps
`default_nettype none

module cycle_control import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       halt,
    input  logic       mem_ready,
    input  decoded_t   dec,
    input  logic       cond_pass,
    input  word_t      pc,
    input  mem_req_t   data_req,
    output cpu_state_t state,
    output logic       ir_load,
    output logic       exec_en,
    output logic       wb_en,
    output logic       pc_step,
    output mem_req_t   mem_req,
    output logic       mem_valid,
    output logic       running
);

    cpu_state_t next_state;
    mem_req_t   fetch_req;
    logic       need_access;
    logic       xfer_done;
    logic       acc_done;    // Access finished while halted, state not yet moved on
    logic       advance;
    logic       started;

    assign fetch_req   = '{addr: pc, wdata: '0, we: 1'b0};
    assign need_access = (state == FETCH) ||
                         (state == MEMORY && dec.cls == CLS_XFER && cond_pass);
    assign xfer_done   = mem_valid && mem_ready;
    assign advance     = !halt && (!need_access || xfer_done || acc_done);

    always_comb begin
        case (state)
            FETCH:   next_state = DECODE;
            DECODE:  next_state = EXECUTE;
            EXECUTE: next_state = MEMORY;
            MEMORY:  next_state = WRITEBACK;
            default: next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FETCH;
            mem_valid <= 1'b0;
            acc_done  <= 1'b0;
            started   <= 1'b0;
        end else begin
            started <= 1'b1;
            // Request held until the single ready pulse, never withdrawn by halt
            if (xfer_done) begin
                mem_valid <= 1'b0;
            end else if (need_access && !mem_valid && !acc_done && !halt) begin
                mem_valid <= 1'b1;
            end
            if (advance) begin
                state    <= next_state;
                acc_done <= 1'b0;
            end else if (xfer_done) begin
                acc_done <= 1'b1;
            end
        end
    end

    assign mem_req = (state == FETCH) ? fetch_req : data_req;

    assign ir_load = (state == FETCH) && xfer_done;
    assign exec_en = (state == EXECUTE) && !halt;
    assign wb_en   = (state == WRITEBACK) && !halt;
    assign pc_step = (state == WRITEBACK) && !halt;
    assign running = started && !halt;

endmodule

`default_nettype wire

//--- verilog/pc_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pc_counter import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pc_step,
    input  decoded_t dec,
    input  logic     cond_pass,
    output word_t    pc
);

    word_t branch_target;
    logic  take_branch;

    // Word offset, relative to the branch's own address
    assign branch_target = pc + {{(xlen-26){dec.offset[23]}}, dec.offset, 2'b00};
    assign take_branch   = (dec.cls == CLS_BRANCH) && cond_pass;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (pc_step) begin
            pc <= take_branch ? branch_target : pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ir_load,
    input  word_t    mem_rdata,
    input  flags_t   flags,
    output decoded_t dec,
    output logic     cond_pass
);

    word_t  ir;
    flags_t flags_at_fetch;
    instr_class_t cls;

    function automatic logic cond_eval(input cond_t c, input flags_t f);
        case (c)
            COND_EQ: return f.z;
            COND_NE: return !f.z;
            COND_CS: return f.c;
            COND_CC: return !f.c;
            COND_MI: return f.n;
            COND_PL: return !f.n;
            COND_VS: return f.v;
            COND_VC: return !f.v;
            COND_HI: return f.c && !f.z;
            COND_LS: return !f.c || f.z;
            COND_GE: return f.n == f.v;
            COND_LT: return f.n != f.v;
            COND_GT: return !f.z && (f.n == f.v);
            COND_LE: return f.z || (f.n != f.v);
            COND_AL: return 1'b1;
            default: return 1'b0;    // NV
        endcase
    endfunction

    // Flags sampled with the word, so a flag-setting op keeps its own condition result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir             <= '0;
            flags_at_fetch <= '0;
        end else if (ir_load) begin
            ir             <= mem_rdata;
            flags_at_fetch <= flags;
        end
    end

    assign cls = instr_class_t'(ir[cls_hi:cls_lo]);

    always_comb begin
        dec.cls       = cls;
        dec.cond      = cond_t'(ir[cond_hi:cond_lo]);
        dec.set_flags = (cls == CLS_DP) && ir[s_bit];
        dec.imm_en    = ir[i_bit];
        dec.load      = (cls == CLS_XFER) && ir[s_bit];
        dec.rd        = ir[rd_hi:rd_lo];
        dec.rn        = ir[rn_hi:rn_lo];
        dec.rm        = ir[rm_hi:rm_lo];
        dec.imm       = ir[imm_hi:imm_lo];
        dec.offset    = ir[off_hi:off_lo];
        case (alu_op_t'(ir[opc_hi:opc_lo]))
            OP_AND, OP_EOR, OP_SUB, OP_ADD, OP_CMP, OP_ORR:
                dec.op = alu_op_t'(ir[opc_hi:opc_lo]);
            default: dec.op = OP_MOV;    // Unsupported opcodes
        endcase
    end

    assign cond_pass = cond_eval(dec.cond, flags_at_fetch);

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_en,
    input  decoded_t dec,
    input  logic     cond_pass,
    input  word_t    alu_result,
    input  word_t    load_data,
    output word_t    rn_data,
    output word_t    rm_data
);

    word_t    regs [reg_count];
    word_t    wr_data;
    reg_idx_t rm_sel;
    logic     wr_en;
    logic     writes_rd;

    // Store data comes out of the second port
    assign rm_sel  = (dec.cls == CLS_XFER && !dec.load) ? dec.rd : dec.rm;
    assign rn_data = regs[dec.rn];
    assign rm_data = regs[rm_sel];

    assign writes_rd = (dec.cls == CLS_DP && dec.op != OP_CMP) ||
                       (dec.cls == CLS_XFER && dec.load);
    assign wr_en     = wb_en && cond_pass && writes_rd && (dec.rd != pc_idx);
    assign wr_data   = (dec.cls == CLS_XFER) ? load_data : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[dec.rd] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_flags.sv
`timescale 1ns/10ps
`default_nettype none

module alu_flags import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     exec_en,
    input  decoded_t dec,
    input  logic     cond_pass,
    input  word_t    rn_data,
    input  word_t    rm_data,
    output word_t    alu_result,
    output flags_t   flags
);

    word_t         op_b;
    word_t         res;
    logic [xlen:0] sum;
    logic [xlen:0] diff;
    logic          c_next;
    logic          v_next;
    logic          flag_upd;

    assign op_b = dec.imm_en ? {{(xlen-8){1'b0}}, dec.imm[7:0]} : rm_data;
    assign sum  = {1'b0, rn_data} + {1'b0, op_b};
    assign diff = {1'b0, rn_data} + {1'b0, ~op_b} + 33'd1;    // Top bit set means no borrow

    always_comb begin
        c_next = flags.c;    // Logical ops keep C and V
        v_next = flags.v;
        case (dec.op)
            OP_AND: res = rn_data & op_b;
            OP_EOR: res = rn_data ^ op_b;
            OP_ORR: res = rn_data | op_b;
            OP_ADD: begin
                res    = sum[xlen-1:0];
                c_next = sum[xlen];
                v_next = (rn_data[xlen-1] == op_b[xlen-1]) && (res[xlen-1] != rn_data[xlen-1]);
            end
            OP_SUB, OP_CMP: begin
                res    = diff[xlen-1:0];
                c_next = diff[xlen];
                v_next = (rn_data[xlen-1] != op_b[xlen-1]) && (res[xlen-1] != rn_data[xlen-1]);
            end
            default: res = op_b;    // MOV
        endcase
    end

    assign flag_upd = exec_en && cond_pass && (dec.cls == CLS_DP) &&
                      (dec.set_flags || dec.op == OP_CMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_result <= '0;
        end else if (exec_en) begin
            alu_result <= res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_upd) begin
            flags <= '{n: res[xlen-1], z: (res == '0), c: c_next, v: v_next};
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module mem_port import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_state_t state,
    input  logic       mem_ready,
    input  decoded_t   dec,
    input  word_t      rn_data,
    input  word_t      rm_data,
    input  word_t      mem_rdata,
    output mem_req_t   data_req,
    output word_t      load_data
);

    // Base plus unsigned 12-bit offset, always a full word
    assign data_req.addr  = rn_data + {{(xlen-12){1'b0}}, dec.imm};
    assign data_req.wdata = rm_data;    // Holds rd for a store
    assign data_req.we    = !dec.load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_data <= '0;
        end else if (state == MEMORY && mem_ready) begin
            load_data <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     halt,
    input  word_t    mem_rdata,
    input  logic     mem_ready,
    output mem_req_t mem_req,
    output logic     mem_valid,
    output logic     running
);

    cpu_state_t state;
    logic       ir_load;
    logic       exec_en;
    logic       wb_en;
    logic       pc_step;
    logic       cond_pass;
    decoded_t   dec;
    flags_t     flags;
    word_t      pc;
    word_t      rn_data;
    word_t      rm_data;
    word_t      alu_result;
    word_t      load_data;
    mem_req_t   data_req;

    cycle_control cycle_control_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .mem_ready (mem_ready),
        .dec       (dec),
        .cond_pass (cond_pass),
        .pc        (pc),
        .data_req  (data_req),
        .state     (state),
        .ir_load   (ir_load),
        .exec_en   (exec_en),
        .wb_en     (wb_en),
        .pc_step   (pc_step),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .running   (running)
    );

    pc_counter pc_counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_step   (pc_step),
        .dec       (dec),
        .cond_pass (cond_pass),
        .pc        (pc)
    );

    instr_decode instr_decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ir_load   (ir_load),
        .mem_rdata (mem_rdata),
        .flags     (flags),
        .dec       (dec),
        .cond_pass (cond_pass)
    );

    reg_file reg_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_en      (wb_en),
        .dec        (dec),
        .cond_pass  (cond_pass),
        .alu_result (alu_result),
        .load_data  (load_data),
        .rn_data    (rn_data),
        .rm_data    (rm_data)
    );

    alu_flags alu_flags_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_en    (exec_en),
        .dec        (dec),
        .cond_pass  (cond_pass),
        .rn_data    (rn_data),
        .rm_data    (rm_data),
        .alu_result (alu_result),
        .flags      (flags)
    );

    mem_port mem_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .mem_ready (mem_ready),
        .dec       (dec),
        .rn_data   (rn_data),
        .rm_data   (rm_data),
        .mem_rdata (mem_rdata),
        .data_req  (data_req),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

//--- tb/mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    input  logic     mem_valid,
    output word_t    mem_rdata,
    output logic     mem_ready,
    input  logic     bd_we,      // Backdoor write for program and data loading
    input  word_t    bd_addr,
    input  word_t    bd_data
);

    word_t      mem [256];
    logic [1:0] delay;
    logic       pending;
    logic       respond;
    logic [7:0] idx;

    assign idx     = mem_req.addr[9:2];    // Word index, 1 KB space
    assign respond = pending && (delay == 2'd0) && !mem_ready;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            pending   <= 1'b0;
            delay     <= 2'd0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;    // One-cycle pulse
            pending   <= 1'b0;
        end else if (respond) begin
            mem_ready <= 1'b1;
            mem_rdata <= mem[idx];
        end else if (mem_valid && !pending) begin
            pending <= 1'b1;
            delay   <= 2'($urandom_range(3, 0));    // Zero to three extra cycles
        end else if (pending) begin
            delay <= delay - 2'd1;
        end
    end

    always @(posedge clk) begin
        if (bd_we) begin
            mem[bd_addr[9:2]] <= bd_data;
        end else if (respond && mem_req.we) begin
            mem[idx] <= mem_req.wdata;
        end
    end

endmodule

`default_nettype wire

//--- tb/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb import core_pkg::*; ();

    logic     clk;
    logic     rst_n;
    logic     halt;
    logic     mem_valid;
    logic     mem_ready;
    logic     running;
    logic     bd_we;
    word_t    bd_addr;
    word_t    bd_data;
    word_t    mem_rdata;
    mem_req_t mem_req;
    mem_req_t prev_req;
    logic     prev_valid;
    logic     prev_ready;
    logic     prev_halt;
    mem_req_t stores [$];    // Every completed store seen at the port
    word_t    prog [$];
    word_t    exp_addr [$];
    word_t    exp_data [$];
    int       first_store;

    core_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .running   (running)
    );

    mem_model mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .bd_we     (bd_we),
        .bd_addr   (bd_addr),
        .bd_data   (bd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic word_t dp_instr(cond_t c, alu_op_t op, int s, int i, int rn, int rd,
                                       int opnd);
        word_t w;
        w                  = '0;
        w[cond_hi:cond_lo] = c;
        w[cls_hi:cls_lo]   = CLS_DP;
        w[i_bit]           = i[0];
        w[opc_hi:opc_lo]   = op;
        w[s_bit]           = s[0];
        w[rn_hi:rn_lo]     = rn[3:0];
        w[rd_hi:rd_lo]     = rd[3:0];
        w[imm_hi:imm_lo]   = opnd[11:0];    // imm8 or rm in the low bits
        return w;
    endfunction

    function automatic word_t xfer_instr(int load, int rn, int rd, int off);
        word_t w;
        w                  = '0;
        w[cond_hi:cond_lo] = COND_AL;
        w[cls_hi:cls_lo]   = CLS_XFER;
        w[s_bit]           = load[0];
        w[rn_hi:rn_lo]     = rn[3:0];
        w[rd_hi:rd_lo]     = rd[3:0];
        w[imm_hi:imm_lo]   = off[11:0];
        return w;
    endfunction

    function automatic word_t branch_instr(int off);
        word_t w;
        w                  = '0;
        w[cond_hi:cond_lo] = COND_AL;
        w[cls_hi:cls_lo]   = CLS_BRANCH;
        w[off_hi:off_lo]   = off[23:0];
        return w;
    endfunction

    function automatic word_t mov_imm(int rd, int imm);
        return dp_instr(COND_AL, OP_MOV, 0, 1, 0, rd, imm);
    endfunction

    task automatic poke(input word_t addr, input word_t data);
        @(posedge clk);
        bd_we   <= 1'b1;
        bd_addr <= addr;
        bd_data <= data;
        @(posedge clk);
        bd_we <= 1'b0;
    endtask

    task automatic run_program();
        @(posedge clk);
        rst_n <= 1'b0;
        halt  <= 1'b0;
        repeat (5) @(posedge clk);
        for (int i = 0; i < prog.size(); i++) begin
            poke(word_t'(4 * i), prog[i]);
        end
        prog.delete();
        first_store = stores.size();
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic wait_stores(input int n);
        for (int t = 0; t < 3000 && stores.size() - first_store < n; t++) begin
            @(posedge clk);
        end
        if (stores.size() - first_store < n) begin
            stop_run("Timeout: the expected store requests never reached the memory port");
        end
    endtask

    task automatic check_stores();
        int n;
        n = exp_addr.size();
        wait_stores(n);
        repeat (40) @(posedge clk);    // Program now spins on its last branch
        assert (stores.size() - first_store == n) else
            stop_run($sformatf("Error at %0t: %0d stores seen, expected %0d", $time,
                               stores.size() - first_store, n));
        for (int i = 0; i < n; i++) begin
            assert (stores[first_store + i].addr == exp_addr[i]) else
                stop_run($sformatf("Error at %0t: store %0d address %h, expected %h", $time,
                                   i, stores[first_store + i].addr, exp_addr[i]));
            assert (stores[first_store + i].wdata == exp_data[i]) else
                stop_run($sformatf("Error at %0t: store %0d data %h, expected %h", $time,
                                   i, stores[first_store + i].wdata, exp_data[i]));
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic test_alu();
        word_t a;
        word_t b;
        a = 32'h5A;
        b = 32'h3C;
        prog.push_back(mov_imm(1, 'h5A));
        prog.push_back(mov_imm(2, 'h3C));
        prog.push_back(dp_instr(COND_AL, OP_ADD, 0, 0, 1, 3, 2));
        prog.push_back(dp_instr(COND_AL, OP_SUB, 0, 0, 1, 4, 2));
        prog.push_back(dp_instr(COND_AL, OP_AND, 0, 0, 1, 5, 2));
        prog.push_back(dp_instr(COND_AL, OP_EOR, 0, 0, 1, 6, 2));
        prog.push_back(dp_instr(COND_AL, OP_ORR, 0, 1, 1, 7, 'h81));
        prog.push_back(mov_imm(10, 'h80));    // Base for the stores
        for (int r = 3; r <= 7; r++) begin
            prog.push_back(xfer_instr(0, 10, r, 'h180 + 4 * (r - 3)));
        end
        prog.push_back(branch_instr(0));
        expect_store(32'h200, a + b);
        expect_store(32'h204, a - b);
        expect_store(32'h208, a & b);
        expect_store(32'h20C, a ^ b);
        expect_store(32'h210, a | 32'h81);
        run_program();
        check_stores();
    endtask

    task automatic test_load();
        poke(32'h240, 32'hCAFE_1234);
        prog.push_back(mov_imm(1, 'h40));
        prog.push_back(xfer_instr(1, 1, 2, 'h200));
        prog.push_back(xfer_instr(0, 1, 2, 'h220));
        prog.push_back(branch_instr(0));
        expect_store(32'h260, 32'hCAFE_1234);
        run_program();
        check_stores();
    endtask

    task automatic test_cond_flags();
        word_t diff;
        logic  eq;
        eq   = (32'd7 == 32'd7);
        diff = 32'd3 - 32'd5;
        prog.push_back(mov_imm(1, 7));
        prog.push_back(mov_imm(2, 7));
        prog.push_back(dp_instr(COND_AL, OP_CMP, 1, 0, 1, 0, 2));
        prog.push_back(dp_instr(COND_EQ, OP_MOV, 0, 1, 0, 3, 'h11));
        prog.push_back(dp_instr(COND_NE, OP_MOV, 0, 1, 0, 4, 'h22));
        prog.push_back(mov_imm(6, 3));
        prog.push_back(dp_instr(COND_AL, OP_SUB, 1, 1, 6, 7, 5));    // SUBS, goes negative
        prog.push_back(dp_instr(COND_MI, OP_MOV, 0, 1, 0, 8, 'h33));
        prog.push_back(dp_instr(COND_PL, OP_MOV, 0, 1, 0, 9, 'h44));
        prog.push_back(mov_imm(10, 'h80));
        prog.push_back(xfer_instr(0, 10, 3, 'h180));
        prog.push_back(xfer_instr(0, 10, 4, 'h184));
        prog.push_back(xfer_instr(0, 10, 7, 'h188));
        prog.push_back(xfer_instr(0, 10, 8, 'h18C));
        prog.push_back(xfer_instr(0, 10, 9, 'h190));
        prog.push_back(branch_instr(0));
        expect_store(32'h200, eq ? 32'h11 : 32'h0);
        expect_store(32'h204, eq ? 32'h0 : 32'h22);
        expect_store(32'h208, diff);
        expect_store(32'h20C, diff[31] ? 32'h33 : 32'h0);
        expect_store(32'h210, diff[31] ? 32'h0 : 32'h44);
        run_program();
        check_stores();
    endtask

    task automatic test_branch();
        prog.push_back(mov_imm(1, 'h55));
        prog.push_back(mov_imm(10, 'h80));
        prog.push_back(xfer_instr(0, 10, 1, 'h180));
        prog.push_back(branch_instr(2));    // Skips the next store
        prog.push_back(xfer_instr(0, 10, 1, 'h184));
        prog.push_back(xfer_instr(0, 10, 1, 'h188));
        prog.push_back(branch_instr(0));
        expect_store(32'h200, 32'h55);
        expect_store(32'h208, 32'h55);
        run_program();
        check_stores();
    endtask

    task automatic test_halt();
        prog.push_back(mov_imm(1, 1));
        prog.push_back(mov_imm(10, 'h80));
        prog.push_back(xfer_instr(0, 10, 1, 'h180));
        prog.push_back(mov_imm(1, 2));
        prog.push_back(xfer_instr(0, 10, 1, 'h184));
        prog.push_back(mov_imm(1, 3));
        prog.push_back(xfer_instr(0, 10, 1, 'h188));
        prog.push_back(branch_instr(0));
        expect_store(32'h200, 32'd1);
        expect_store(32'h204, 32'd2);
        expect_store(32'h208, 32'd3);
        run_program();
        wait_stores(1);
        assert (running) else
            stop_run($sformatf("Error at %0t: running low while the core executes", $time));
        @(posedge clk);
        halt <= 1'b1;    // Monitor watches running and new requests meanwhile
        repeat (15) @(posedge clk);
        halt <= 1'b0;
        check_stores();
    endtask

    // Port monitor, sampled values are those of the cycle just ended
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_valid && mem_ready && mem_req.we) begin
                stores.push_back(mem_req);
            end
            if (prev_valid && !prev_ready && mem_valid) begin
                assert (mem_req == prev_req) else
                    stop_run($sformatf("Error at %0t: request changed before ready", $time));
            end
            assert (!(prev_ready && mem_valid)) else
                stop_run($sformatf("Error at %0t: mem_valid high after mem_ready", $time));
            assert (!(halt && running)) else
                stop_run($sformatf("Error at %0t: running high during halt", $time));
            assert (!(prev_halt && !prev_valid && mem_valid)) else
                stop_run($sformatf("Error at %0t: new request started during halt", $time));
        end
        prev_req   <= mem_req;
        prev_valid <= mem_valid;
        prev_ready <= mem_ready;
        prev_halt  <= halt;
    end

    initial begin
        void'($urandom(32'h9f30e259));
        rst_n   <= 1'b0;
        halt    <= 1'b0;
        bd_we   <= 1'b0;
        bd_addr <= '0;
        bd_data <= '0;
        test_alu();
        test_load();
        test_cond_flags();
        test_branch();
        test_halt();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/core_pkg.sv
verilog/cycle_control.sv
verilog/pc_counter.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/alu_flags.sv
verilog/mem_port.sv
verilog/core_top.sv
tb/mem_model.sv
tb/core_tb.sv

//--- run.sh
#!/bin/bash
# Build the core testbench with Verilator, run it, and judge by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module core_tb -f filelist.f -o core_sim \
    && ./obj_dir/core_sim 2>&1 | tee sim.log \
    || echo "Build or simulation did not complete"

grep -q "All tests passed" sim.log && exit 0 || exit 1
